// ==== mandel_render.f ====
design/mandel_fix_pkg.sv
design/mandel_frame_pkg.sv
design/mandel_pixel_scan.sv
design/mandel_iter_unit.sv
design/mandel_cal_cluster.sv
design/mandel_core.sv
sim/mandel_chk.sv
sim/mandel_tb.sv

// ==== Bender.yml ====
package:
  name: mandel_render

sources:
  # packages come first, the fixed-point package before the frame package.
  - design/mandel_fix_pkg.sv
  - design/mandel_frame_pkg.sv
  - design/mandel_pixel_scan.sv
  - design/mandel_iter_unit.sv
  - design/mandel_cal_cluster.sv
  - design/mandel_core.sv

  - target: simulation
    files:
      - sim/mandel_chk.sv
      - sim/mandel_tb.sv

// ==== sim/mandel_tb.sv ====
// Mandelbrot core testbench that renders frames under several waitrequest patterns and checks them.
module mandel_tb;

    typedef enum logic [1:0] {
        wr_never,                              // bus always ready.
        wr_third,                              // stall in every third cycle.
        wr_random,                             // stall with 50% chance.
        wr_burst                               // 20 stalled cycles, then 20 free ones.
    } wait_mode_e;

    typedef struct packed {
        wait_mode_e mode;                      // waitrequest pattern for this frame.
        logic [7:0] idle;                      // idle cycles before the start pulse.
        logic       poke;                      // pulse start again in the middle of the frame.
    } test_row_t;

    logic                       clk;
    logic                       arst_n;
    logic                       start;
    logic                       waitrequest;
    logic                       busy;
    logic                       frame_done;
    mandel_frame_pkg::vram_wr_t vram;

    test_row_t test_table [4] = '{
        '{wr_never,  8'd3, 1'b0},
        '{wr_third,  8'd5, 1'b1},
        '{wr_random, 8'd2, 1'b0},
        '{wr_burst,  8'd7, 1'b0}
    };

    logic [mandel_frame_pkg::vram_aw-1:0] exp_addr
        [mandel_frame_pkg::h_display * mandel_frame_pkg::v_display]; // raster address per write.
    mandel_fix_pkg::iter_t exp_count
        [mandel_frame_pkg::h_display * mandel_frame_pkg::v_display]; // model count per write.

    wait_mode_e  wait_mode;                    // pattern the driver applies now.
    logic [31:0] rng_state;                    // xorshift state.
    int          cyc_cnt;                      // cycles seen by the waitrequest driver.
    int          wr_idx;                       // accepted writes in the current frame.
    int          n_checks;
    int          n_errors;
    int          n_failed;                     // tests with at least one error.
    logic        held_q;                       // a write was stalled in the last cycle.
    logic [mandel_frame_pkg::vram_aw-1:0] held_addr;
    logic [mandel_frame_pkg::vram_dw-1:0] held_data;

    mandel_core dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .vram        (vram),
        .waitrequest (waitrequest),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                // period of 100.
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // keeps the low 16 bits and sign-extends them, as a Q4.12 register would.
    function automatic int wrap16(input int v);
        logic signed [15:0] t;
        t = v[15:0];
        return int'(t);
    endfunction

    // escape-time reference; int arithmetic wraps at 32 bits like the products in hardware.
    function automatic mandel_fix_pkg::iter_t ref_count(input int col, input int row);
        int cr;
        int ci;
        int zr;
        int zi;
        int zr_new;
        int zr2;
        int zi2;
        int zrzi;
        int n;
        cr = wrap16(mandel_frame_pkg::start_x + col * mandel_frame_pkg::delta_x);
        ci = wrap16(mandel_frame_pkg::start_y + row * mandel_frame_pkg::delta_y);
        zr = 0;
        zi = 0;
        zr2 = 0;
        zi2 = 0;
        zrzi = 0;
        n = 0;
        while ((((zr2 + zi2) >>> mandel_fix_pkg::frac_w) < mandel_fix_pkg::threshold) &&
               (n < mandel_fix_pkg::max_iter)) begin
            zr_new = wrap16(((zr2 - zi2) >>> mandel_fix_pkg::frac_w) + cr);
            zi     = wrap16(((2 * zrzi) >>> mandel_fix_pkg::frac_w) + ci);
            zr     = zr_new;
            zr2    = zr * zr;
            zi2    = zi * zi;
            zrzi   = zr * zi;
            n++;
        end
        return mandel_fix_pkg::iter_t'(n);
    endfunction

    task automatic check_addr(input int pix, input logic [mandel_frame_pkg::vram_aw-1:0] got,
                              input logic [mandel_frame_pkg::vram_aw-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("[FAIL] vram.address write %0d got 0x%h expected 0x%h", pix, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_data(input int pix, input logic [mandel_frame_pkg::vram_dw-1:0] got,
                              input logic [mandel_frame_pkg::vram_dw-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("[FAIL] vram.writedata write %0d got 0x%h expected 0x%h", pix, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_count(input int pix, input mandel_fix_pkg::iter_t got,
                               input mandel_fix_pkg::iter_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("[FAIL] count write %0d got 0x%h expected 0x%h", pix, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            n_errors++;
        end
    endtask

    // waitrequest follows the pattern of the running test.
    always begin
        @(posedge clk);
        #10;
        cyc_cnt++;
        case (wait_mode)
            wr_third:  waitrequest = (cyc_cnt % 3 == 0);
            wr_random: begin
                rng_state   = xorshift32(rng_state);
                waitrequest = rng_state[0];
            end
            wr_burst:  waitrequest = (cyc_cnt % 40 < 20);
            default:   waitrequest = 1'b0;
        endcase
    end

    // every accepted write is compared with the model in raster order.
    always @(posedge clk) begin
        if (arst_n && held_q &&
            (!vram.write || vram.address !== held_addr || vram.writedata !== held_data)) begin
            $display("stalled write changed its values while waitrequest was high");
            n_errors++;
        end
        if (arst_n && vram.write && !waitrequest) begin
            if (wr_idx >= $size(exp_addr)) begin
                $display("write accepted after the frame was already complete");
                n_errors++;
            end else begin
                check_addr(wr_idx, vram.address, exp_addr[wr_idx]);
                check_data(wr_idx, vram.writedata,
                           mandel_frame_pkg::vram_dw'(exp_count[wr_idx]));
                check_count(wr_idx, mandel_fix_pkg::iter_t'(vram.writedata),
                            exp_count[wr_idx]);
            end
            wr_idx++;
        end
        held_q    = arst_n && vram.write && waitrequest;
        held_addr = vram.address;
        held_data = vram.writedata;
    end

    task automatic run_test(input int t);
        test_row_t row;
        int        errs_before;
        int        asrt_before;
        row = test_table[t];
        errs_before = n_errors;
        asrt_before = dut_i.chk_i.fail_cnt;
        wait_mode = row.mode;
        repeat (row.idle) begin
            @(posedge clk);
            #10;
            check_flag("vram.write", vram.write, 1'b0);      // nothing moves before start.
            check_flag("busy", busy, 1'b0);
            check_flag("frame_done", frame_done, 1'b0);
        end
        wr_idx = 0;
        @(posedge clk);
        #10;
        start = 1'b1;
        @(posedge clk);
        #10;
        start = 1'b0;
        check_flag("busy", busy, 1'b1);                      // busy from the cycle after start.
        if (row.poke) begin
            repeat (40) @(posedge clk);
            #10;
            start = 1'b1;                                    // must be ignored mid-frame.
            @(posedge clk);
            #10;
            start = 1'b0;
        end
        while (!frame_done) begin
            @(posedge clk);
            #10;
        end
        check_flag("busy", busy, 1'b0);                      // busy falls with the done pulse.
        if (wr_idx != $size(exp_addr)) begin
            $display("frame of test %0d ended after %0d writes instead of %0d",
                     t, wr_idx, $size(exp_addr));
            n_errors++;
        end
        if (dut_i.chk_i.fail_cnt != asrt_before) begin
            $display("checker assertions failed %0d times during test %0d",
                     dut_i.chk_i.fail_cnt - asrt_before, t);
            n_errors += dut_i.chk_i.fail_cnt - asrt_before;
        end
        if (n_errors != errs_before) begin
            n_failed++;
        end
        $display("test %0d (%s, %0d idle cycles): %0d writes, %0d errors",
                 t, row.mode.name(), row.idle, wr_idx, n_errors - errs_before);
    endtask

    initial begin
        arst_n      = 1'b0;
        start       = 1'b0;
        waitrequest = 1'b0;
        wait_mode   = wr_never;
        rng_state   = 32'haabe_b135;
        cyc_cnt     = 0;
        wr_idx      = 0;
        n_checks    = 0;
        n_errors    = 0;
        n_failed    = 0;
        held_q      = 1'b0;
        for (int r = 0; r < mandel_frame_pkg::v_display; r++) begin
            for (int c = 0; c < mandel_frame_pkg::h_display; c++) begin
                exp_addr[r * mandel_frame_pkg::h_display + c] =
                    mandel_frame_pkg::vram_aw'(c + r * mandel_frame_pkg::h_display);
                exp_count[r * mandel_frame_pkg::h_display + c] = ref_count(c, r);
            end
        end
        repeat (3) @(posedge clk);
        #10;
        arst_n = 1'b1;
        for (int t = 0; t < $size(test_table); t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 $size(test_table), n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // worst case is every pixel at the cap, doubled for stalls.
    initial begin
        longint limit;
        limit = longint'($size(test_table)) * $size(exp_addr) *
                (mandel_fix_pkg::max_iter + 2) * 2 * 100;
        #(limit);
        $display("watchdog expired, the run timed out before all frames finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sim/mandel_chk.sv ====
// Mandelbrot core checker with concurrent assertions on the VRAM port and the result handshake.
module mandel_chk (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            busy,
    input  logic                            frame_start,
    input  mandel_frame_pkg::vram_wr_t      vram,
    input  logic                            waitrequest,
    input  logic                            frame_done,
    input  mandel_frame_pkg::pixel_result_t res,
    input  logic                            res_valid,
    input  logic                            res_ready,
    input  logic                            cal_done,
    input  logic [7:0]                      wr_cnt
);

    int fail_cnt = 0;                          // assertion failures so far.

    // a stalled write keeps its request, address and data until the bus takes it.
    hold_under_wait: assert property (@(posedge clk) disable iff (!arst_n)
        (vram.write && waitrequest) |=>
            (vram.write && $stable(vram.address) && $stable(vram.writedata)))
        else begin
            $error("write changed while waitrequest was high");
            fail_cnt++;
        end

    // frame_done is one cycle long and only comes once every write has drained.
    done_single: assert property (@(posedge clk) disable iff (!arst_n)
        frame_done |-> (!vram.write && !res_valid) ##1 !frame_done)
        else begin
            $error("frame_done came with work pending or stayed high too long");
            fail_cnt++;
        end

    // a start is only taken up once the previous frame has fully drained.
    start_idle_only: assert property (@(posedge clk) disable iff (!arst_n)
        frame_start |-> (!vram.write && !res_valid && wr_cnt == 8'd0) ##1 busy)
        else begin
            $error("start acted on while a frame was still in flight");
            fail_cnt++;
        end

    // an offered result keeps its payload until the write register takes it.
    res_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(res)))
        else begin
            $error("result dropped or changed before res_ready");
            fail_cnt++;
        end

    // the cluster finishes when the last result sits in the write register and 191 are out.
    cal_done_count: assert property (@(posedge clk) disable iff (!arst_n)
        cal_done |-> (vram.write && (wr_cnt == 8'(mandel_frame_pkg::h_display *
                                                 mandel_frame_pkg::v_display - 1))))
        else begin
            $error("cal_done does not line up with the write count");
            fail_cnt++;
        end

endmodule

bind mandel_core mandel_chk chk_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .busy        (busy),
    .frame_start (frame_start),
    .vram        (vram),
    .waitrequest (waitrequest),
    .frame_done  (frame_done),
    .res         (res),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .cal_done    (cal_done),
    .wr_cnt      (wr_cnt_q)
);

// ==== design/mandel_core.sv ====
// Mandelbrot core that turns escape counts into VRAM writes and tracks frame completion.
module mandel_core (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    output mandel_frame_pkg::vram_wr_t vram,
    input  logic                       waitrequest,
    output logic                       busy,
    output logic                       frame_done
);

    mandel_frame_pkg::pixel_result_t res;        // result offered by the cluster.
    logic                            res_valid;  // cluster has a result.
    logic                            res_ready;  // the write register can take it.
    logic                            cal_done;   // cluster saw the last result leave.
    logic                            frame_start;// start that is acted on.
    logic                            accept;     // the bus takes the held write.
    logic                            wr_q;       // write request held on the bus.
    logic [mandel_frame_pkg::vram_aw-1:0] addr_q;  // address of the held write.
    logic [mandel_frame_pkg::vram_dw-1:0] data_q;  // data of the held write.
    logic [$clog2(mandel_frame_pkg::h_display * mandel_frame_pkg::v_display)-1:0] wr_cnt_q;

    assign frame_start = start & ~busy;          // a start during a frame is ignored.
    assign accept      = wr_q & ~waitrequest;
    assign res_ready   = ~wr_q | accept;         // free now or freed at this edge.

    mandel_cal_cluster u_cluster (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (frame_start),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .cal_done  (cal_done)
    );

    // write request, frame bookkeeping and the done pulse.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_q       <= 1'b0;
            busy       <= 1'b0;
            frame_done <= 1'b0;
            wr_cnt_q   <= '0;
        end else begin
            frame_done <= 1'b0;
            if (frame_start) begin
                busy <= 1'b1;
            end
            if (res_valid && res_ready) begin
                wr_q <= 1'b1;                    // next write follows right behind.
            end else if (accept) begin
                wr_q <= 1'b0;
            end
            if (accept) begin
                if (wr_cnt_q == $bits(wr_cnt_q)'(mandel_frame_pkg::h_display *
                                                 mandel_frame_pkg::v_display - 1)) begin
                    wr_cnt_q   <= '0;
                    busy       <= 1'b0;          // falls together with the done pulse.
                    frame_done <= 1'b1;
                end else begin
                    wr_cnt_q <= wr_cnt_q + 1'b1;
                end
            end
        end
    end

    // address and data only change when a new result is taken, so they hold under wait.
    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            addr_q <= mandel_frame_pkg::vram_aw'(res.column) +
                      mandel_frame_pkg::vram_aw'(res.row) *
                      mandel_frame_pkg::vram_aw'(mandel_frame_pkg::h_display);
            data_q <= mandel_frame_pkg::vram_dw'(res.count);
        end
    end

    assign vram = '{write: wr_q, address: addr_q, writedata: data_q};

endmodule

// ==== design/mandel_cal_cluster.sv ====
// Mandelbrot calculation cluster that spreads pixel jobs over two iteration units in order.
module mandel_cal_cluster (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            start,
    output mandel_frame_pkg::pixel_result_t res,
    output logic                            res_valid,
    input  logic                            res_ready,
    output logic                            cal_done
);

    mandel_frame_pkg::pixel_job_t    job;               // job offered by the scanner.
    logic                            job_valid;         // scanner has a job.
    logic                            job_ready;         // the addressed unit can take it.
    logic                            scan_done;         // every job has left the scanner.
    logic                            disp_ptr;          // unit that receives the next job.
    logic                            ret_ptr;           // unit whose result is due next.
    logic                            job_xfer;          // a job moves at this edge.
    logic                            res_xfer;          // a result moves at this edge.
    logic                            last_pixel;        // presented result is the bottom-right one.
    logic [1:0]                      unit_job_valid;    // job_valid steered per unit.
    logic [1:0]                      unit_job_ready;    // job_ready of each unit.
    logic [1:0]                      unit_res_valid;    // res_valid of each unit.
    logic [1:0]                      unit_res_ready;    // res_ready steered per unit.
    mandel_frame_pkg::pixel_result_t unit_res [2];      // result of each unit.

    mandel_pixel_scan u_scan (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .job       (job),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .scan_done (scan_done)
    );

    for (genvar k = 0; k < 2; k++) begin : g_unit
        // valid reaches only the unit the pointer names, so it never waits on ready.
        assign unit_job_valid[k] = job_valid & (disp_ptr == 1'(k));
        assign unit_res_ready[k] = res_ready & (ret_ptr == 1'(k));

        mandel_iter_unit u_iter (
            .clk       (clk),
            .arst_n    (arst_n),
            .job       (job),
            .job_valid (unit_job_valid[k]),
            .job_ready (unit_job_ready[k]),
            .result    (unit_res[k]),
            .res_valid (unit_res_valid[k]),
            .res_ready (unit_res_ready[k])
        );
    end

    assign job_ready = unit_job_ready[disp_ptr];
    assign res       = unit_res[ret_ptr];
    assign res_valid = unit_res_valid[ret_ptr];
    assign job_xfer  = job_valid & job_ready;
    assign res_xfer  = res_valid & res_ready;

    assign last_pixel =
        (res.column == mandel_frame_pkg::xcnt_t'(mandel_frame_pkg::h_display - 1)) &&
        (res.row == mandel_frame_pkg::ycnt_t'(mandel_frame_pkg::v_display - 1));

    // both pointers alternate; with an even pixel count they meet at zero again per frame.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            disp_ptr <= 1'b0;
            ret_ptr  <= 1'b0;
            cal_done <= 1'b0;
        end else begin
            if (job_xfer) begin
                disp_ptr <= ~disp_ptr;
            end
            if (res_xfer) begin
                ret_ptr <= ~ret_ptr;           // results retire in the order jobs left.
            end
            // the bottom-right result only counts once the scanner has finished.
            cal_done <= res_xfer & last_pixel & scan_done;
        end
    end

endmodule

// ==== design/mandel_iter_unit.sv ====
// Mandelbrot iteration unit that runs the escape-time loop for one pixel, one step per clock.
module mandel_iter_unit (
    input  logic                            clk,
    input  logic                            arst_n,
    input  mandel_frame_pkg::pixel_job_t    job,
    input  logic                            job_valid,
    output logic                            job_ready,
    output mandel_frame_pkg::pixel_result_t result,
    output logic                            res_valid,
    input  logic                            res_ready
);

    typedef enum logic [1:0] {
        st_idle,                               // waiting for a job.
        st_run,                                // one iteration per clock.
        st_hold                                // result offered until taken.
    } state_t;

    state_t                       state_q;     // current FSM state.
    mandel_frame_pkg::pixel_job_t job_q;       // job being worked on.
    mandel_fix_pkg::fix_t         zr_q;        // real part of z.
    mandel_fix_pkg::fix_t         zi_q;        // imaginary part of z.
    mandel_fix_pkg::iter_t        count_q;     // iterations done so far.
    mandel_fix_pkg::wide_t        zr_sq;       // zr squared.
    mandel_fix_pkg::wide_t        zi_sq;       // zi squared.
    mandel_fix_pkg::wide_t        zr_zi;       // zr times zi.
    mandel_fix_pkg::wide_t        mag;         // |z|^2 back in Q4.12 scale.
    mandel_fix_pkg::wide_t        zr_next;     // next zr before truncation.
    mandel_fix_pkg::wide_t        zi_next;     // next zi before truncation.
    logic                         stop;        // escaped or hit the cap.

    // the three multipliers and the update terms of one iteration.
    always_comb begin
        zr_sq   = mandel_fix_pkg::wide_t'(zr_q) * mandel_fix_pkg::wide_t'(zr_q);
        zi_sq   = mandel_fix_pkg::wide_t'(zi_q) * mandel_fix_pkg::wide_t'(zi_q);
        zr_zi   = mandel_fix_pkg::wide_t'(zr_q) * mandel_fix_pkg::wide_t'(zi_q);
        mag     = (zr_sq + zi_sq) >>> mandel_fix_pkg::frac_w;
        stop    = (mag >= mandel_fix_pkg::threshold) ||
                  (count_q == mandel_fix_pkg::iter_t'(mandel_fix_pkg::max_iter));
        zr_next = ((zr_sq - zi_sq) >>> mandel_fix_pkg::frac_w) +
                  mandel_fix_pkg::wide_t'(job_q.cr);
        zi_next = ((zr_zi <<< 1) >>> mandel_fix_pkg::frac_w) +
                  mandel_fix_pkg::wide_t'(job_q.ci);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            zr_q    <= '0;
            zi_q    <= '0;
            count_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (job_valid) begin
                        state_q <= st_run;     // load cycle, z starts at zero.
                        zr_q    <= '0;
                        zi_q    <= '0;
                        count_q <= '0;
                    end
                end
                st_run: begin
                    if (stop) begin
                        state_q <= st_hold;    // count_q now holds the final count.
                    end else begin
                        zr_q    <= mandel_fix_pkg::fix_t'(zr_next);
                        zi_q    <= mandel_fix_pkg::fix_t'(zi_next);
                        count_q <= count_q + 1'b1;
                    end
                end
                st_hold: begin
                    if (res_ready) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // the job payload is captured with the handshake and kept for the whole run.
    always_ff @(posedge clk) begin
        if (job_ready && job_valid) begin
            job_q <= job;
        end
    end

    assign job_ready = (state_q == st_idle);
    assign res_valid = (state_q == st_hold);
    assign result    = '{column: job_q.column, row: job_q.row, count: count_q};

endmodule

// ==== design/mandel_pixel_scan.sv ====
// Mandelbrot pixel scanner that walks the frame in raster order and offers one job per pixel.
module mandel_pixel_scan (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         start,
    output mandel_frame_pkg::pixel_job_t job,
    output logic                         job_valid,
    input  logic                         job_ready,
    output logic                         scan_done
);

    logic                          xfer;       // a job moves to the cluster at this edge.
    logic                          last_col;   // current job sits in the right-most column.
    logic                          last_row;   // current job sits in the bottom row.
    mandel_frame_pkg::xcnt_t       col_q;      // column of the offered job.
    mandel_frame_pkg::ycnt_t       row_q;      // row of the offered job.
    mandel_fix_pkg::fix_t          cr_q;       // running real coordinate.
    mandel_fix_pkg::fix_t          ci_q;       // running imaginary coordinate.

    assign xfer     = job_valid & job_ready;
    assign last_col = (col_q == mandel_frame_pkg::xcnt_t'(mandel_frame_pkg::h_display - 1));
    assign last_row = (row_q == mandel_frame_pkg::ycnt_t'(mandel_frame_pkg::v_display - 1));

    // counters and the valid flag; a start rewinds the scan to the top-left pixel.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            job_valid <= 1'b0;
            scan_done <= 1'b0;
            col_q     <= '0;
            row_q     <= '0;
        end else if (start) begin
            job_valid <= 1'b1;                 // first job is offered in the next cycle.
            scan_done <= 1'b0;
            col_q     <= '0;
            row_q     <= '0;
        end else if (xfer) begin
            if (last_col) begin
                col_q <= '0;                   // wrap to the start of the next row.
                if (last_row) begin
                    job_valid <= 1'b0;         // the final pixel has been handed over.
                    scan_done <= 1'b1;         // stays up until the next start.
                    row_q     <= '0;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // coordinates follow the counters by adding the steps, so no multiplier is needed.
    always_ff @(posedge clk) begin
        if (start) begin
            cr_q <= mandel_frame_pkg::start_x;
            ci_q <= mandel_frame_pkg::start_y;
        end else if (xfer) begin
            if (last_col) begin
                cr_q <= mandel_frame_pkg::start_x;           // back to the left edge.
                ci_q <= ci_q + mandel_frame_pkg::delta_y;    // one row further down.
            end else begin
                cr_q <= cr_q + mandel_frame_pkg::delta_x;    // wraps in 16 bits.
            end
        end
    end

    assign job = '{column: col_q, row: row_q, cr: cr_q, ci: ci_q};

endmodule

// ==== design/mandel_frame_pkg.sv ====
// Mandelbrot frame package with geometry, coordinate steps and the job, result and VRAM structs.
package mandel_frame_pkg;

    localparam int h_display = 16;             // columns per frame.
    localparam int v_display = 12;             // rows per frame.

    typedef logic [$clog2(h_display)-1:0] xcnt_t;  // column index.
    typedef logic [$clog2(v_display)-1:0] ycnt_t;  // row index.

    // top-left corner of the view, -2.0 on the real axis and -1.0 on the imaginary axis.
    localparam mandel_fix_pkg::fix_t start_x =
        mandel_fix_pkg::fix_t'(-2 * (1 << mandel_fix_pkg::frac_w));
    localparam mandel_fix_pkg::fix_t start_y =
        mandel_fix_pkg::fix_t'(-1 * (1 << mandel_fix_pkg::frac_w));

    // per-pixel steps; the view spans 3.0 by 2.0 and the division truncates.
    localparam mandel_fix_pkg::fix_t delta_x =
        mandel_fix_pkg::fix_t'((3 << mandel_fix_pkg::frac_w) / h_display);
    localparam mandel_fix_pkg::fix_t delta_y =
        mandel_fix_pkg::fix_t'((2 << mandel_fix_pkg::frac_w) / v_display);

    localparam int vram_aw = 19;               // VRAM word address width.
    localparam int vram_dw = 16;               // VRAM data width.

    typedef struct packed {
        xcnt_t                column;          // pixel column, carried to the result.
        ycnt_t                row;             // pixel row, carried to the result.
        mandel_fix_pkg::fix_t cr;              // real part of c.
        mandel_fix_pkg::fix_t ci;              // imaginary part of c.
    } pixel_job_t;

    typedef struct packed {
        xcnt_t                 column;         // pixel column.
        ycnt_t                 row;            // pixel row.
        mandel_fix_pkg::iter_t count;          // escape count.
    } pixel_result_t;

    typedef struct packed {
        logic               write;             // request, taken when waitrequest is low.
        logic [vram_aw-1:0] address;           // raster index of the pixel.
        logic [vram_dw-1:0] writedata;         // zero-extended escape count.
    } vram_wr_t;

endpackage

// ==== design/mandel_fix_pkg.sv ====
// Mandelbrot fixed-point package with the Q4.12 number format, iteration cap and escape bound.
package mandel_fix_pkg;

    localparam int fix_w  = 16;                // total width of a coordinate or z value.
    localparam int frac_w = 12;                // fraction bits, leaving 4 integer bits.

    // signed Q4.12 value, used for cr, ci, zr and zi.
    typedef logic signed [fix_w-1:0] fix_t;

    // signed product of two fix_t values, wide enough for every square in range.
    typedef logic signed [2*fix_w-1:0] wide_t;

    localparam int max_iter = 255;             // a pixel that survives this long is inside.

    // escape count, sized so that max_iter itself still fits.
    typedef logic [$clog2(max_iter+1)-1:0] iter_t;

    // |z|^2 is compared against 4.0 without a square root.
    localparam wide_t threshold = wide_t'(4 << frac_w);

endpackage
